/* hw/lms_defs.svh */
// widths and counts for the fixed-point LMS predictor; TAPS must be a multiple of LANES
`ifndef LMS_DEFS_SVH
`define LMS_DEFS_SVH

// filter size
`define TAPS      16 // coefficients and delay-line stages
`define LANES     8  // shared arithmetic lanes

// data widths
`define SAMPLE_W  16 // input samples and desired value
`define COEF_W    32 // coefficients and error

// Q16 fraction, so a coefficient of 1.0 is 1 << COEF_FRAC
`define COEF_FRAC 16

// one lane operand must hold a full sum of 16 products
`define ACC_W     56

// step size is 2^-mu_shift
`define MU_W      5

// value of every coefficient after reset
`define COEF_INIT 0

`endif

/* hw/lms_pkg.sv */
// shared data types and enums; widths come from lms_defs.svh and all values are two's complement
`include "lms_defs.svh"

package lms_pkg;

	// payload types
	typedef logic signed [`SAMPLE_W-1:0] sample_t; // raw sample or desired value
	typedef logic signed [`COEF_W-1:0]   coef_t;   // Q.COEF_FRAC coefficient
	typedef logic signed [`COEF_W-1:0]   err_t;    // prediction error, same scale as desired
	typedef logic signed [`ACC_W-1:0]    acc_t;    // lane operand and result

	// operation issued to one lane
	typedef enum logic [1:0] {
		op_mul, // a * b
		op_mac, // held result + a * b
		op_add, // a + b
		op_sub  // a - b
	} lane_op_t;

	// sequencer phases, one pass runs dot through update
	typedef enum logic [2:0] {
		ph_idle,
		ph_dot,    // tap times coefficient, accumulated per lane
		ph_reduce, // pairwise tree down to one sum
		ph_error,  // desired minus prediction
		ph_scale,  // error times tap
		ph_update  // coefficient plus scaled product
	} phase_t;

endpackage

/* hw/tap_delay_line.sv */
// taps and desired hold no reset value; only full is valid right after reset
`timescale 1ns/1ps
`include "lms_defs.svh"

module tap_delay_line (
	input  logic              clk_operation,
	input  logic              rst,
	input  logic              sample_strobe,
	input  lms_pkg::sample_t  signal,
	input  lms_pkg::sample_t  signal_lag,
	output lms_pkg::sample_t  taps [`TAPS],
	output lms_pkg::sample_t  desired,
	output logic              full
);

	import lms_pkg::*;

	localparam int CNT_W = $clog2(`TAPS) + 1;
	localparam logic [CNT_W-1:0] FILL_MAX = CNT_W'(`TAPS);

	logic [CNT_W-1:0] fill_cnt; // strobes seen, stops at TAPS

	// shift register, index 0 is the newest sample
	always_ff @(posedge clk_operation) begin
		if (sample_strobe) begin
			taps[0] <= signal;
			for (int i = 1; i < `TAPS; i++) begin
				taps[i] <= taps[i-1];
			end
			desired <= signal_lag; // lines up with the sample just taken
		end
	end

	always_ff @(posedge clk_operation) begin
		if (!rst) begin
			fill_cnt <= '0;
		end else if (sample_strobe && !full) begin
			fill_cnt <= fill_cnt + 1'b1; // saturates once the line is full
		end
	end

	assign full = (fill_cnt == FILL_MAX);

	// once full, the line stays full until the next reset
	a_full_sticky: assert property (
		@(posedge clk_operation) disable iff (!rst)
		full |=> full
	);

endmodule

/* hw/arith_lane.sv */
// single-cycle fixed-point lane; products and sums wrap to ACC_W bits without saturation
`timescale 1ns/1ps
`include "lms_defs.svh"

module arith_lane (
	input  logic               clk_operation,
	input  logic               rst,
	input  logic               start,
	input  lms_pkg::lane_op_t  op,
	input  lms_pkg::acc_t      a,
	input  lms_pkg::acc_t      b,
	output lms_pkg::acc_t      result,
	output logic               done
);

	import lms_pkg::*;

	acc_t product; // shared by mul and mac

	assign product = a * b; // low ACC_W bits kept

	// result is held between starts so mac can build on it
	always_ff @(posedge clk_operation) begin
		if (start) begin
			case (op)
				op_mul: result <= product;
				op_mac: result <= result + product;
				op_add: result <= a + b;
				op_sub: result <= a - b;
			endcase
		end
	end

	always_ff @(posedge clk_operation) begin
		if (!rst) begin
			done <= 1'b0;
		end else begin
			done <= start; // one pulse per start
		end
	end

	// done answers one cycle after start, before the lane is issued again
	a_done_latency: assert property (
		@(posedge clk_operation) disable iff (!rst)
		start |=> (done && !start)
	);

endmodule

/* hw/lms_sequencer.sv */
// one pass takes 20 cycles; start is ignored unless idle and full, and there is no back-pressure
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_sequencer (
	input  logic                clk_operation,
	input  logic                rst,
	input  logic                start,
	input  logic                full,
	input  logic [`MU_W-1:0]    mu_shift,
	input  lms_pkg::sample_t    taps [`TAPS],
	input  lms_pkg::sample_t    desired,
	input  lms_pkg::acc_t       lane_result [`LANES],
	input  logic [`LANES-1:0]   lane_done,
	output logic [`LANES-1:0]   lane_start,
	output lms_pkg::lane_op_t   lane_op [`LANES],
	output lms_pkg::acc_t       lane_a [`LANES],
	output lms_pkg::acc_t       lane_b [`LANES],
	output lms_pkg::coef_t      para [`TAPS],
	output lms_pkg::err_t       e,
	output logic                ready
);

	import lms_pkg::*;

	localparam int LANES = `LANES;
	localparam int CNT_W = 4;
	localparam logic [CNT_W-1:0] GRP_LAST = CNT_W'(`TAPS / `LANES - 1); // dot, scale, update
	localparam logic [CNT_W-1:0] RED_LAST = CNT_W'($clog2(`LANES) - 1); // reduce tree depth

	phase_t         phase;
	logic [CNT_W-1:0] cnt;    // step within the phase
	logic           wait_q;   // 0 = issue cycle, 1 = collect cycle
	logic           accept;
	logic           issue;
	logic           collect;
	logic           last_step;

	sample_t tap_snap [`TAPS]; // taps frozen for the whole pass
	sample_t desired_snap;
	acc_t    partial [`LANES]; // per-lane sums during dot and reduce
	acc_t    prod [`TAPS];     // e * tap, before the mu shift

	assign accept  = (phase == ph_idle) && start && full;
	assign issue   = (phase != ph_idle) && !wait_q;
	assign collect = (phase != ph_idle) && wait_q && lane_done[0]; // lane 0 works in every step

	always_comb begin
		case (phase)
			ph_dot:    last_step = (cnt == GRP_LAST);
			ph_reduce: last_step = (cnt == RED_LAST);
			ph_scale:  last_step = (cnt == GRP_LAST);
			ph_update: last_step = (cnt == GRP_LAST);
			default:   last_step = 1'b1; // error is a single step
		endcase
	end

	// operand routing, idx picks the tap group of the current step
	always_comb begin
		int idx;
		for (int k = 0; k < LANES; k++) begin
			idx = int'(cnt) * LANES + k;
			lane_start[k] = 1'b0;
			lane_op[k] = op_add;
			lane_a[k] = '0;
			lane_b[k] = '0;
			case (phase)
				ph_dot: begin
					lane_start[k] = issue;
					lane_op[k] = (cnt == '0) ? op_mul : op_mac;
					lane_a[k] = acc_t'(tap_snap[idx]);
					lane_b[k] = acc_t'(para[idx]);
				end
				ph_reduce: begin
					lane_start[k] = issue && (k < (LANES >> (cnt + 1'b1))); // 4, 2, 1 lanes
					lane_a[k] = partial[(2 * k) % LANES];
					lane_b[k] = partial[(2 * k + 1) % LANES];
				end
				ph_error: begin
					lane_start[k] = issue && (k == 0);
					lane_op[k] = op_sub;
					lane_a[k] = acc_t'(desired_snap);
					lane_b[k] = partial[0] >>> `COEF_FRAC; // back to sample scale
				end
				ph_scale: begin
					lane_start[k] = issue;
					lane_op[k] = op_mul;
					lane_a[k] = acc_t'(e);
					lane_b[k] = acc_t'(tap_snap[idx]);
				end
				ph_update: begin
					lane_start[k] = issue;
					lane_a[k] = acc_t'(para[idx]);
					lane_b[k] = prod[idx] >>> mu_shift; // step size 2^-mu_shift
				end
				default: ;
			endcase
		end
	end

	// snapshot and partial results
	always_ff @(posedge clk_operation) begin
		if (accept) begin
			tap_snap <= taps;
			desired_snap <= desired;
		end
		if (collect) begin
			for (int k = 0; k < LANES; k++) begin
				case (phase)
					ph_dot, ph_reduce: partial[k] <= lane_result[k];
					ph_scale:          prod[int'(cnt) * LANES + k] <= lane_result[k];
					default: ;
				endcase
			end
		end
	end

	// phase walk, error and coefficient registers
	always_ff @(posedge clk_operation) begin
		if (!rst) begin
			phase <= ph_idle;
			cnt <= '0;
			wait_q <= 1'b0;
			ready <= 1'b0;
			e <= '0;
			for (int i = 0; i < `TAPS; i++) begin
				para[i] <= coef_t'(`COEF_INIT);
			end
		end else if (accept) begin
			phase <= ph_dot;
			cnt <= '0;
			wait_q <= 1'b0;
			ready <= 1'b0; // busy until the update steps finish
		end else if (issue) begin
			wait_q <= 1'b1;
		end else if (collect) begin
			wait_q <= 1'b0;
			cnt <= last_step ? '0 : cnt + 1'b1;
			case (phase)
				ph_dot: begin
					if (last_step) phase <= ph_reduce;
				end
				ph_reduce: begin
					if (last_step) phase <= ph_error;
				end
				ph_error: begin
					e <= err_t'(lane_result[0][`COEF_W-1:0]);
					phase <= ph_scale;
				end
				ph_scale: begin
					if (last_step) phase <= ph_update;
				end
				ph_update: begin
					for (int k = 0; k < LANES; k++) begin
						para[int'(cnt) * LANES + k] <= coef_t'(lane_result[k][`COEF_W-1:0]);
					end
					if (last_step) begin
						phase <= ph_idle;
						ready <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	// outputs are only valid while ready is high
	a_ready_low_when_busy: assert property (
		@(posedge clk_operation) disable iff (!rst)
		(phase != ph_idle) |-> !ready
	);

	// every lane issued in a step answers in the same collect cycle
	a_lanes_done_together: assert property (
		@(posedge clk_operation) disable iff (!rst)
		(|lane_start) |=> (lane_done == $past(lane_start))
	);

endmodule

/* hw/lms_predictor_top.sv */
// predictor top; para and e are valid while ready is high, first pass needs TAPS strobes
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_predictor_top (
	input  logic               clk_operation,
	input  logic               rst,
	input  logic               sample_strobe,
	input  lms_pkg::sample_t   signal,
	input  lms_pkg::sample_t   signal_lag,
	input  logic               start,
	input  logic [`MU_W-1:0]   mu_shift,
	output lms_pkg::coef_t     para [`TAPS],
	output lms_pkg::err_t      e,
	output logic               ready
);

	import lms_pkg::*;

	sample_t           taps [`TAPS];
	sample_t           desired;
	logic              full;
	logic [`LANES-1:0] lane_start;
	logic [`LANES-1:0] lane_done;
	lane_op_t          lane_op [`LANES];
	acc_t              lane_a [`LANES];
	acc_t              lane_b [`LANES];
	acc_t              lane_result [`LANES];

	tap_delay_line u_delay (
		.clk_operation (clk_operation),
		.rst           (rst),
		.sample_strobe (sample_strobe),
		.signal        (signal),
		.signal_lag    (signal_lag),
		.taps          (taps),
		.desired       (desired),
		.full          (full)
	);

	lms_sequencer u_seq (
		.clk_operation (clk_operation),
		.rst           (rst),
		.start         (start),
		.full          (full),
		.mu_shift      (mu_shift),
		.taps          (taps),
		.desired       (desired),
		.lane_result   (lane_result),
		.lane_done     (lane_done),
		.lane_start    (lane_start),
		.lane_op       (lane_op),
		.lane_a        (lane_a),
		.lane_b        (lane_b),
		.para          (para),
		.e             (e),
		.ready         (ready)
	);

	// eight shared lanes
	for (genvar g = 0; g < `LANES; g++) begin : g_lane
		arith_lane u_lane (
			.clk_operation (clk_operation),
			.rst           (rst),
			.start         (lane_start[g]),
			.op            (lane_op[g]),
			.a             (lane_a[g]),
			.b             (lane_b[g]),
			.result        (lane_result[g]),
			.done          (lane_done[g])
		);
	end

endmodule

/* verif/lms_ref_model.svh */
// expected values for one LMS pass; intermediates fit in 64 bits, so only final truncations apply
`ifndef LMS_REF_MODEL_SVH
`define LMS_REF_MODEL_SVH

sample_t model_line [`TAPS]; // index 0 is the newest sample
sample_t model_desired;      // desired value of the newest sample
sample_t model_snap [`TAPS]; // line as seen when a pass starts
sample_t model_snap_desired;
coef_t   model_coef [`TAPS];

// back to the state right after reset
function automatic void clear_model();
	for (int i = 0; i < `TAPS; i++) begin
		model_line[i] = '0;
		model_coef[i] = coef_t'(`COEF_INIT);
	end
	model_desired = '0;
endfunction

// one strobe, newest sample enters at index 0
function automatic void push_sample(input sample_t s, input sample_t d);
	for (int i = `TAPS - 1; i > 0; i--) begin
		model_line[i] = model_line[i-1];
	end
	model_line[0] = s;
	model_desired = d;
endfunction

function automatic void freeze_line();
	model_snap = model_line;
	model_snap_desired = model_desired;
endfunction

// full-precision sum of tap times coefficient
function automatic longint predict_sum();
	longint sum;
	sum = 0;
	for (int i = 0; i < `TAPS; i++) begin
		sum += longint'(model_snap[i]) * longint'(model_coef[i]);
	end
	return sum;
endfunction

// desired minus prediction, low COEF_W bits
function automatic err_t predict_error(input longint sum);
	longint diff;
	diff = longint'(model_snap_desired) - (sum >>> `COEF_FRAC);
	return diff[`COEF_W-1:0];
endfunction

// coefficient plus error times tap scaled by 2^-mu
function automatic void adapt_coefs(input err_t err, input int unsigned mu);
	longint step;
	longint next;
	for (int i = 0; i < `TAPS; i++) begin
		step = (longint'(err) * longint'(model_snap[i])) >>> mu;
		next = longint'(model_coef[i]) + step;
		model_coef[i] = next[`COEF_W-1:0];
	end
endfunction

`endif

/* verif/lms_tb.sv */
// self-checking testbench for lms_predictor_top; mu_shift is held stable for the whole of a pass
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_tb;

	import lms_pkg::*;

	localparam int CYCLE_LIMIT  = 4000; // about twice the length of all tests
	localparam int RAMP_DESIRED = 1000;
	localparam int RAMP_MU      = 4;

	logic             clk_operation;
	logic             rst;
	logic             sample_strobe;
	logic             start;
	sample_t          signal;
	sample_t          signal_lag;
	logic [`MU_W-1:0] mu_shift;
	coef_t            para [`TAPS];
	err_t             e;
	logic             ready;

	`include "lms_ref_model.svh"

	integer seed;
	int     cycle_cnt = 0;
	int     test_cnt = 0;
	int     test_fail_cnt = 0;
	int     error_cnt = 0;
	int     errs;
	int     n_new;
	int     unsigned mu;
	logic   pass_pending = 1'b0; // a pass was launched and awaits its result
	logic   ready_seen = 1'b0;
	string  pass_name;
	err_t   exp_e;
	coef_t  exp_para [`TAPS];

	lms_predictor_top dut (
		.clk_operation (clk_operation),
		.rst           (rst),
		.sample_strobe (sample_strobe),
		.signal        (signal),
		.signal_lag    (signal_lag),
		.start         (start),
		.mu_shift      (mu_shift),
		.para          (para),
		.e             (e),
		.ready         (ready)
	);

	initial begin
		clk_operation = 1'b0;
		forever #50 clk_operation = ~clk_operation;
	end

	always @(posedge clk_operation) cycle_cnt <= cycle_cnt + 1;

	initial begin
		while (cycle_cnt < CYCLE_LIMIT) @(posedge clk_operation);
		$display("timeout: no result after %0d cycles", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

	// one summary line per finished test
	task automatic close_test(input string name, input int n_err);
		test_cnt++;
		error_cnt += n_err;
		if (n_err == 0) begin
			$display("%s: ok", name);
		end else begin
			test_fail_cnt++;
			$display("%s: FAIL, %0d mismatches", name, n_err);
		end
	endtask

	// called at a falling edge and returns at one
	task automatic strobe_in(input sample_t s, input sample_t d);
		sample_strobe = 1'b1;
		signal = s;
		signal_lag = d;
		push_sample(s, d);
		@(negedge clk_operation);
		sample_strobe = 1'b0;
		@(negedge clk_operation);
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge clk_operation);
		start = 1'b0;
	endtask

	// start a pass and load the expected result from the model
	task automatic launch_pass(input string name, input int unsigned mu_val);
		err_t err;
		mu_shift = mu_val[`MU_W-1:0];
		freeze_line();
		err = predict_error(predict_sum());
		adapt_coefs(err, mu_val);
		exp_e = err;
		exp_para = model_coef;
		pass_name = name;
		pass_pending = 1'b1;
		pulse_start();
	endtask

	task automatic await_result();
		wait (!pass_pending);
		@(negedge clk_operation);
	endtask

	// outputs sampled at the falling edge after ready rises
	always @(negedge clk_operation) begin
		int n_err;
		if (rst && ready && !ready_seen) begin
			if (!pass_pending) begin
				$display("ready rose while no pass was in progress");
				error_cnt++;
			end else begin
				n_err = 0;
				if (e !== exp_e) begin
					$display("error %s e expected %0d actual %0d", pass_name, exp_e, e);
					n_err++;
				end
				for (int i = 0; i < `TAPS; i++) begin
					if (para[i] !== exp_para[i]) begin
						$display("error %s para[%0d] expected %0d actual %0d",
							pass_name, i, exp_para[i], para[i]);
						n_err++;
					end
				end
				close_test(pass_name, n_err);
				pass_pending = 1'b0;
			end
		end
		ready_seen = ready;
	end

	initial begin
		seed = 97;
		rst = 1'b0;
		sample_strobe = 1'b0;
		start = 1'b0;
		signal = '0;
		signal_lag = '0;
		mu_shift = '0;
		clear_model();
		repeat (4) @(posedge clk_operation);
		@(negedge clk_operation);
		rst = 1'b1;

		errs = 0;
		if (ready !== 1'b0) begin
			$display("error reset_state ready expected 0 actual %b", ready);
			errs++;
		end
		if (e !== '0) begin
			$display("error reset_state e expected 0 actual %0d", e);
			errs++;
		end
		for (int i = 0; i < `TAPS; i++) begin
			if (para[i] !== coef_t'(`COEF_INIT)) begin
				$display("error reset_state para[%0d] expected %0d actual %0d",
					i, `COEF_INIT, para[i]);
				errs++;
			end
		end
		close_test("reset_state", errs);

		// start must be ignored while the line holds 5 samples
		for (int i = 0; i < 5; i++) strobe_in(sample_t'(101 + i), sample_t'(7));
		pulse_start();
		errs = 0;
		repeat (40) begin
			@(negedge clk_operation);
			if (ready !== 1'b0) errs++;
		end
		if (errs != 0) $display("ready went high after a start with the line not full");
		close_test("start_before_full", errs);

		// ramp 1..16 with all coefficients still zero
		for (int i = 0; i < `TAPS; i++) strobe_in(sample_t'(i + 1), sample_t'(RAMP_DESIRED));
		launch_pass("ramp_pass", RAMP_MU);
		exp_e = err_t'(RAMP_DESIRED); // prediction is zero
		for (int i = 0; i < `TAPS; i++) begin
			exp_para[i] = coef_t'((RAMP_DESIRED * (`TAPS - i)) >>> RAMP_MU);
		end
		await_result();

		for (int p = 0; p < 25; p++) begin
			n_new = 1 + ($unsigned($random(seed)) % `TAPS);
			for (int i = 0; i < n_new; i++) begin
				strobe_in(sample_t'($random(seed)), sample_t'($random(seed)));
			end
			mu = 2 + ($unsigned($random(seed)) % 11);
			launch_pass($sformatf("random_pass_%0d", p), mu);
			await_result();
		end

		// strobes and a second start while busy
		launch_pass("strobes_during_pass", 6);
		for (int i = 0; i < 3; i++) begin
			strobe_in(sample_t'($random(seed)), sample_t'($random(seed)));
		end
		pulse_start(); // dropped while the sequencer is busy
		await_result();
		errs = 0;
		repeat (30) begin
			@(negedge clk_operation);
			if (ready !== 1'b1) errs++;
		end
		if (errs != 0) $display("a start given during a pass was not dropped");
		close_test("busy_start_dropped", errs);
		launch_pass("strobes_next_pass", 6);
		await_result();

		$display("tests %0d, failed %0d, mismatches %0d", test_cnt, test_fail_cnt, error_cnt);
		if (error_cnt == 0 && test_fail_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
+incdir+verif
hw/lms_pkg.sv
hw/tap_delay_line.sv
hw/arith_lane.sv
hw/lms_sequencer.sv
hw/lms_predictor_top.sv
verif/lms_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := lms_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
FAIL_MSG   := Test failed
PASS_MSG   := Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
